//--- files.f
sim_mem_pkg.sv
ram_1p.sv
wb_sram_adapter.sv
wb_window_split.sv
sim_mem_top.sv
sim_mem_sva.sv
tb_sim_mem.sv

//--- tb_sim_mem.sv
/*
 * Testbench for the simulation memory tap.
 * Runs directed edge cycles and LFSR-chosen cycles, models the outbound
 * slave and checks each response against shadow and reference models.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_sim_mem;

  localparam int          Depth    = 64;
  localparam logic [31:0] SramBase = 32'h1000_0000;
  localparam int          IdxBits  = $clog2(Depth);
  localparam int          NumRand  = 200;
  localparam int          NumTxn   = NumRand + 6;
  localparam int          MaxWait  = 16;

  // Expected outcome of one cycle is queued when the cycle is issued.
  typedef struct packed {
    logic        loc_hit;
    logic        we;
    logic        err;
    logic [1:0]  waits;
    logic [31:0] dat;
  } exp_t;

  logic                 clk_i;
  logic                 rst_ni;
  sim_mem_pkg::wb_req_t up_req_i;
  sim_mem_pkg::wb_rsp_t up_rsp_o;
  sim_mem_pkg::wb_req_t dn_req_o;
  sim_mem_pkg::wb_rsp_t dn_rsp_i;

  logic [31:0] lfsr_q;
  logic [31:0] shadow [Depth];
  logic        shadow_ok [Depth];
  exp_t        exp_q [$];
  logic [1:0]  dn_waits;

  sim_mem_top i_dut (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .up_req_i(up_req_i),
    .up_rsp_o(up_rsp_o),
    .dn_req_o(dn_req_o),
    .dn_rsp_i(dn_rsp_i)
  );

  // 32-bit Fibonacci LFSR with taps 32 22 2 1.
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // One LFSR step per bit taken.
  task automatic draw(input int n, output logic [31:0] val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_step(lfsr_q);
      val    = {val[30:0], lfsr_q[0]};
    end
  endtask

  // Read data that the outbound slave returns for an address.
  function automatic logic [31:0] out_data(input logic [31:0] adr);
    return adr ^ 32'hA5A5_5A5A;
  endfunction

  // Bytes selected by sel come from the new word.
  function automatic logic [31:0] merge_bytes(input logic [31:0] old_w,
                                              input logic [31:0] new_w,
                                              input logic [3:0]  sel);
    logic [31:0] res;
    for (int b = 0; b < 4; b++) begin
      res[b*8 +: 8] = sel[b] ? new_w[b*8 +: 8] : old_w[b*8 +: 8];
    end
    return res;
  endfunction

  function automatic logic in_window(input logic [31:0] adr);
    return (adr >= SramBase) && (adr < SramBase + Depth * 4);
  endfunction

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Done: errors found");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) else begin
      fail_run($sformatf("[FAIL] %0t ns %s: expected %h, got %h", $time, name, exp, got));
    end
  endtask

  // One Wishbone classic cycle; the outcome is queued for the checker first.
  task automatic wb_cycle(input logic [31:0] adr, input logic we, input logic [31:0] dat,
                          input logic [3:0] sel, input logic [1:0] waits);
    exp_t                 e;
    sim_mem_pkg::wb_req_t req;
    int                   idx;
    int                   n;
    e.loc_hit = in_window(adr);
    e.we      = we;
    e.waits   = waits;
    if (e.loc_hit) begin
      idx = (adr - SramBase) / 4;
      if (we) begin
        shadow[idx]    = merge_bytes(shadow[idx], dat, sel);
        shadow_ok[idx] = 1'b1;
      end
      e.err = 1'b0;
      e.dat = shadow[idx];
    end else begin
      // Outbound slave flags an error when address bits 3 and 2 are set.
      e.err = adr[3] & adr[2];
      e.dat = out_data(adr);
    end
    exp_q.push_back(e);
    dn_waits = waits;
    req      = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat, sel: sel};
    @(posedge clk_i);
    up_req_i <= req;
    n = 0;
    do begin
      @(posedge clk_i);
      n++;
    end while (!(up_rsp_o.ack || up_rsp_o.err) && n < MaxWait);
    assert (up_rsp_o.ack || up_rsp_o.err) else begin
      fail_run($sformatf("no ack or err within %0d clocks for address %h", MaxWait, adr));
    end
    up_req_i <= '0;
  endtask

  task automatic random_cycle();
    logic [31:0] hitb;
    logic [31:0] we;
    logic [31:0] sel;
    logic [31:0] dat;
    logic [31:0] waits;
    logic [31:0] r;
    logic [31:0] adr;
    draw(1, hitb);
    draw(1, we);
    draw(4, sel);
    draw(32, dat);
    draw(2, waits);
    if (hitb[0]) begin
      draw(IdxBits, r);
      adr = SramBase + r * 4;
      // First access to a word is a full write, so reads see known data.
      if (!shadow_ok[r]) begin
        we  = 1;
        sel = 4'hf;
      end
    end else begin
      draw(32, r);
      adr = {r[31:2], 2'b00};
      if (in_window(adr)) adr[31] = ~adr[31];
    end
    wb_cycle(adr, we[0], dat, sel[3:0], waits[1:0]);
  endtask

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  // Outbound slave with 0 to 3 wait states.
  initial begin : outbound_slave
    sim_mem_pkg::wb_rsp_t rsp;
    forever begin
      @(posedge clk_i);
      if (dn_req_o.cyc && dn_req_o.stb) begin
        repeat (dn_waits) @(posedge clk_i);
        rsp.err = dn_req_o.adr[3] & dn_req_o.adr[2];
        rsp.ack = ~rsp.err;
        rsp.dat = dn_req_o.we ? '0 : out_data(dn_req_o.adr);
        dn_rsp_i <= rsp;
        @(posedge clk_i);
        dn_rsp_i <= '0;
      end
    end
  end

  // Checker that samples every rising edge.
  initial begin : compare
    exp_t e;
    int   busy;
    busy = 0;
    forever begin
      @(posedge clk_i);
      if (!(up_req_i.cyc && up_req_i.stb)) begin
        check_value("up_rsp_o.ack", up_rsp_o.ack, 0);
        check_value("up_rsp_o.err", up_rsp_o.err, 0);
        check_value("dn_req_o.cyc", dn_req_o.cyc, 0);
        check_value("dn_req_o.stb", dn_req_o.stb, 0);
      end else begin
        busy++;
        if (in_window(up_req_i.adr)) begin
          check_value("dn_req_o.cyc", dn_req_o.cyc, 0);
          check_value("dn_req_o.stb", dn_req_o.stb, 0);
        end else begin
          // Misses reach the outbound port unchanged.
          check_value("dn_req_o.cyc", dn_req_o.cyc, 1);
          check_value("dn_req_o.stb", dn_req_o.stb, 1);
          check_value("dn_req_o.adr", dn_req_o.adr, up_req_i.adr);
          check_value("dn_req_o.we", dn_req_o.we, up_req_i.we);
          check_value("dn_req_o.dat", dn_req_o.dat, up_req_i.dat);
          check_value("dn_req_o.sel", dn_req_o.sel, up_req_i.sel);
        end
        if (up_rsp_o.ack || up_rsp_o.err) begin
          assert (exp_q.size() != 0) else begin
            fail_run("response arrived with no cycle outstanding");
          end
          e = exp_q.pop_front();
          check_value("response latency", busy, e.loc_hit ? 2 : 2 + e.waits);
          check_value("up_rsp_o.err", up_rsp_o.err, e.err);
          check_value("up_rsp_o.ack", up_rsp_o.ack, !e.err);
          if (!e.loc_hit) begin
            check_value("up_rsp_o.ack vs dn_rsp_i.ack", up_rsp_o.ack, dn_rsp_i.ack);
            check_value("up_rsp_o.err vs dn_rsp_i.err", up_rsp_o.err, dn_rsp_i.err);
          end
          if (!e.we && !e.err) check_value("up_rsp_o.dat", up_rsp_o.dat, e.dat);
          busy = 0;
        end
      end
    end
  end

  initial begin : watchdog
    repeat (NumTxn * 10 + 100) @(posedge clk_i);
    fail_run("watchdog expired before all cycles completed");
  end

  initial begin : main
    rst_ni   = 1'b0;
    up_req_i = '0;
    dn_rsp_i = '0;
    dn_waits = '0;
    lfsr_q   = 32'h89a8_7f19;
    foreach (shadow_ok[i]) shadow_ok[i] = 1'b0;
    repeat (3) @(posedge clk_i);
    rst_ni <= 1'b1;
    // First and last window words are local and their neighbours go outbound.
    wb_cycle(SramBase, 1'b1, 32'h1111_2222, 4'hf, 2'd0);
    wb_cycle(SramBase + (Depth - 1) * 4, 1'b1, 32'h3333_4444, 4'hf, 2'd0);
    wb_cycle(SramBase, 1'b0, 32'h0, 4'hf, 2'd0);
    wb_cycle(SramBase + (Depth - 1) * 4, 1'b0, 32'h0, 4'hf, 2'd1);
    wb_cycle(SramBase - 4, 1'b0, 32'h0, 4'hf, 2'd2);
    wb_cycle(SramBase + Depth * 4, 1'b1, 32'hdead_beef, 4'h3, 2'd3);
    repeat (NumRand) random_cycle();
    repeat (2) @(posedge clk_i);
    check_value("cycles left unanswered", exp_q.size(), 0);
    if (i_dut.i_sva.fail_cnt == 0) begin
      $display("Done: no errors");
      $finish;
    end else begin
      $display("Done: errors found");
      $fatal(1, "protocol assertions failed during the run");
    end
  end

endmodule

`default_nettype wire

//--- sim_mem_sva.sv
/*
 * Wishbone protocol assertions for the simulation memory tap.
 * Bound into the top level, watching the upstream port.
 */
`timescale 1ns/1ps
`default_nettype none

module sim_mem_sva (
  input logic                 clk_i,
  input logic                 rst_ni,
  input sim_mem_pkg::wb_req_t up_req_i,
  input sim_mem_pkg::wb_rsp_t up_rsp_o
);

  // Counts assertion failures for the check at the end of the run.
  int fail_cnt = 0;

  // A cycle ends with ack or with err, never both.
  ack_err_excl: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(up_rsp_o.ack && up_rsp_o.err))
    else begin
      $error("up_rsp_o ack and err high in the same clock");
      fail_cnt++;
    end

  // One strobe gets one ack, so ack never lasts two clocks.
  ack_single: assert property (@(posedge clk_i) disable iff (!rst_ni)
    up_rsp_o.ack |=> !up_rsp_o.ack)
    else begin
      $error("up_rsp_o ack high for two clocks in a row");
      fail_cnt++;
    end

  // A response only answers a live cycle.
  rsp_needs_stb: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (up_rsp_o.ack || up_rsp_o.err) |-> (up_req_i.cyc && up_req_i.stb))
    else begin
      $error("up_rsp_o responded without cyc and stb");
      fail_cnt++;
    end

endmodule

bind sim_mem_top sim_mem_sva i_sva (.*);

`default_nettype wire

//--- sim_mem_top.sv
/*
 * Simulation memory tap on a Wishbone classic bus.
 * Serves a Depth-word window at SramBase from a local RAM and forwards
 * every other cycle to the outbound port.
 */
`timescale 1ns/1ps
`default_nettype none

module sim_mem_top #(
  parameter int                                Depth    = 64,
  parameter logic [sim_mem_pkg::AddrWidth-1:0] SramBase = 32'h1000_0000
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,

  // Upstream master port.
  input  sim_mem_pkg::wb_req_t up_req_i,
  output sim_mem_pkg::wb_rsp_t up_rsp_o,

  // Outbound slave port.
  output sim_mem_pkg::wb_req_t dn_req_o,
  input  sim_mem_pkg::wb_rsp_t dn_rsp_i
);

  localparam int RamAw = $clog2(Depth);

  // Local Wishbone leg between splitter and adapter.
  sim_mem_pkg::wb_req_t loc_req;
  sim_mem_pkg::wb_rsp_t loc_rsp;

  // RAM command and read data.
  logic                              ram_req;
  logic                              ram_we;
  logic [RamAw-1:0]                  ram_addr;
  logic [sim_mem_pkg::DataWidth-1:0] ram_wdata;
  logic [sim_mem_pkg::DataWidth-1:0] ram_wmask;
  logic [sim_mem_pkg::DataWidth-1:0] ram_rdata;

  wb_window_split #(
    .Depth   (Depth),
    .SramBase(SramBase)
  ) u_split (
    .up_req_i (up_req_i),
    .up_rsp_o (up_rsp_o),
    .loc_req_o(loc_req),
    .loc_rsp_i(loc_rsp),
    .dn_req_o (dn_req_o),
    .dn_rsp_i (dn_rsp_i)
  );

  wb_sram_adapter #(
    .Depth(Depth)
  ) u_adapter (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .wb_req_i   (loc_req),
    .wb_rsp_o   (loc_rsp),
    .ram_req_o  (ram_req),
    .ram_we_o   (ram_we),
    .ram_addr_o (ram_addr),
    .ram_wdata_o(ram_wdata),
    .ram_wmask_o(ram_wmask),
    .ram_rdata_i(ram_rdata)
  );

  // Read data is registered here, in step with the adapter ack.
  ram_1p #(
    .Depth(Depth)
  ) u_ram (
    .clk_i  (clk_i),
    .req_i  (ram_req),
    .write_i(ram_we),
    .addr_i (ram_addr),
    .wdata_i(ram_wdata),
    .wmask_i(ram_wmask),
    .rdata_o(ram_rdata)
  );

endmodule

`default_nettype wire

//--- wb_window_split.sv
/*
 * Wishbone address window splitter.
 * Cycles inside the SRAM window go to the local slave, all others to
 * the outbound port; the response comes back from the same side.
 */
`timescale 1ns/1ps
`default_nettype none

module wb_window_split #(
  parameter int                                Depth    = 64,
  parameter logic [sim_mem_pkg::AddrWidth-1:0] SramBase = 32'h1000_0000
) (
  // Upstream master.
  input  sim_mem_pkg::wb_req_t up_req_i,
  output sim_mem_pkg::wb_rsp_t up_rsp_o,

  // Local SRAM slave.
  output sim_mem_pkg::wb_req_t loc_req_o,
  input  sim_mem_pkg::wb_rsp_t loc_rsp_i,

  // Outbound slave.
  output sim_mem_pkg::wb_req_t dn_req_o,
  input  sim_mem_pkg::wb_rsp_t dn_rsp_i
);

  // Window size in bytes.
  localparam int WinBytes = Depth * sim_mem_pkg::SelWidth;

  // Lowest address bit that is compared against the base.
  localparam int WinLsb = $clog2(WinBytes);

  // Number of compared upper bits.
  localparam int TagWidth = sim_mem_pkg::AddrWidth - WinLsb;

  // Base tag, taken once from the aligned base address.
  localparam logic [TagWidth-1:0] BaseTag = SramBase[sim_mem_pkg::AddrWidth-1:WinLsb];

  logic [TagWidth-1:0] up_tag;
  logic                hit;

  // Window decode.
  // The master holds adr for the whole cycle, so hit is stable too.
  assign up_tag = up_req_i.adr[sim_mem_pkg::AddrWidth-1:WinLsb];
  assign hit    = (up_tag == BaseTag);

  // Request steering.
  // Payload fields go to both sides unchanged.
  // Only cyc and stb are gated toward the selected side.
  always_comb begin
    loc_req_o     = up_req_i;
    loc_req_o.cyc = up_req_i.cyc & hit;
    loc_req_o.stb = up_req_i.stb & hit;

    dn_req_o      = up_req_i;
    dn_req_o.cyc  = up_req_i.cyc & ~hit;
    dn_req_o.stb  = up_req_i.stb & ~hit;
  end

  // Response return.
  // Outbound ack and err pass through in the same clock.
  // Classic Wishbone keeps only one side busy at a time.
  always_comb begin
    if (hit) begin
      up_rsp_o = loc_rsp_i;
    end else begin
      up_rsp_o = dn_rsp_i;
    end
  end

endmodule

`default_nettype wire

//--- wb_sram_adapter.sv
/*
 * Wishbone classic slave to SRAM adapter.
 * Each strobe becomes exactly one RAM access; the acknowledge is
 * registered, so it lands in the same clock as the RAM read data.
 */
`timescale 1ns/1ps
`default_nettype none

module wb_sram_adapter #(
  parameter int Depth = 64
) (
  input  logic                              clk_i,
  input  logic                              rst_ni,

  // Wishbone slave side.
  input  sim_mem_pkg::wb_req_t              wb_req_i,
  output sim_mem_pkg::wb_rsp_t              wb_rsp_o,

  // RAM side.
  output logic                              ram_req_o,
  output logic                              ram_we_o,
  output logic [$clog2(Depth)-1:0]          ram_addr_o,
  output logic [sim_mem_pkg::DataWidth-1:0] ram_wdata_o,
  output logic [sim_mem_pkg::DataWidth-1:0] ram_wmask_o,
  input  logic [sim_mem_pkg::DataWidth-1:0] ram_rdata_i
);

  // Word index width.
  localparam int RamAw = $clog2(Depth);

  // Byte lane bits below the word index.
  localparam int LaneBits = $clog2(sim_mem_pkg::SelWidth);

  logic access;
  logic ack_q;

  // A new access needs a live strobe and no ack in the previous clock.
  // This keeps one strobe from being acknowledged twice.
  assign access = wb_req_i.cyc & wb_req_i.stb & ~ack_q;

  // Acknowledge one clock after the access.
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= access;
    end
  end

  // RAM command.
  // Word index sits just above the byte lanes.
  assign ram_req_o   = access;
  assign ram_we_o    = wb_req_i.we;
  assign ram_addr_o  = wb_req_i.adr[LaneBits +: RamAw];
  assign ram_wdata_o = wb_req_i.dat;

  // Widen each select bit over its byte.
  always_comb begin
    for (int i = 0; i < sim_mem_pkg::SelWidth; i++) begin
      ram_wmask_o[i*8 +: 8] = {8{wb_req_i.sel[i]}};
    end
  end

  // Response.
  // Read data comes straight from the RAM output register.
  // The local RAM has no error condition.
  assign wb_rsp_o.ack = ack_q;
  assign wb_rsp_o.err = 1'b0;
  assign wb_rsp_o.dat = ram_rdata_i;

endmodule

`default_nettype wire

//--- ram_1p.sv
/*
 * Single-port synchronous RAM.
 * Writes update only the bits set in the write mask; reads return the
 * addressed word one clock later on a registered output.
 */
`timescale 1ns/1ps
`default_nettype none

module ram_1p #(
  parameter int Depth = 64
) (
  input  logic                              clk_i,
  input  logic                              req_i,
  input  logic                              write_i,
  input  logic [$clog2(Depth)-1:0]          addr_i,
  input  logic [sim_mem_pkg::DataWidth-1:0] wdata_i,
  input  logic [sim_mem_pkg::DataWidth-1:0] wmask_i,
  output logic [sim_mem_pkg::DataWidth-1:0] rdata_o
);

  // Word storage.
  // Contents are unknown until a word is first written.
  logic [sim_mem_pkg::DataWidth-1:0] mem_q [Depth];

  // Masked write.
  // Bits outside the mask keep their old value.
  always_ff @(posedge clk_i) begin
    if (req_i && write_i) begin
      mem_q[addr_i] <= (mem_q[addr_i] & ~wmask_i) | (wdata_i & wmask_i);
    end
  end

  // Registered read port.
  // A write leaves the last read data in place.
  always_ff @(posedge clk_i) begin
    if (req_i && !write_i) begin
      rdata_o <= mem_q[addr_i];
    end
  end

endmodule

`default_nettype wire

//--- sim_mem_pkg.sv
/*
 * Simulation memory tap shared definitions.
 * Bus widths and the Wishbone classic request and response structs
 * used by every block between the upstream master and the outbound port.
 */
`default_nettype none

package sim_mem_pkg;

  // Byte address width of the Wishbone bus.
  parameter int AddrWidth = 32;

  // Data word width.
  parameter int DataWidth = 32;

  // One select bit per byte lane.
  parameter int SelWidth = DataWidth / 8;

  // Request bundle, driven by a master.
  // Adr, we, dat and sel stay stable until ack or err.
  typedef struct packed {
    logic                 cyc;
    logic                 stb;
    logic                 we;
    logic [AddrWidth-1:0] adr;
    logic [DataWidth-1:0] dat;
    logic [SelWidth-1:0]  sel;
  } wb_req_t;

  // Response bundle, driven by a slave.
  // At most one of ack and err is high, for a single clock.
  typedef struct packed {
    logic                 ack;
    logic                 err;
    logic [DataWidth-1:0] dat;
  } wb_rsp_t;

endpackage

`default_nettype wire
